/* Makefile */
# Verilator build and run for the serial slave testbench

VERILATOR ?= verilator
TOP       ?= tb_serial_slave
BUILD_DIR ?= obj_dir
FILELIST  ?= build.f
LOG       ?= sim.log
PASS_TEXT ?= All checks passed
VFLAGS    ?= --binary --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless the log shows the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* build.f */
design/slave_pkg.sv
design/config_receiver.sv
design/write_deserializer.sv
design/word_memory.sv
design/transfer_controller.sv
design/serial_slave.sv
verification/tb_serial_slave.sv

/* design/config_receiver.sv */
//----------------------------
// config receiver
// shifts in the serial setup frame on control, checks
// start pattern and slave id, strobes the decoded setup
//----------------------------
module config_receiver #(
    parameter slave_pkg::slave_id_t SLAVE_ID = '0
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 control,
    input  logic                 busy,
    output logic                 cfg_valid,
    output slave_pkg::xfer_cfg_t cfg
);

    localparam int FB        = slave_pkg::FRAME_BITS;
    localparam int CFG_BITS  = $bits(slave_pkg::xfer_cfg_t);
    localparam int START_MSB = FB - 1;
    localparam int ID_MSB    = FB - 1 - $bits(slave_pkg::START_CODE);

    typedef logic [FB-1:0]         frame_t;
    typedef logic [$clog2(FB)-1:0] bit_cnt_t;

    localparam bit_cnt_t LAST_BIT = bit_cnt_t'(FB - 1);

    frame_t   frame_q;
    frame_t   frame_next;
    bit_cnt_t bit_cnt;
    logic     receiving;
    logic     frame_start;
    logic     frame_done;
    logic     frame_match;

    // first high bit on control opens a frame
    assign frame_start = !receiving && !busy && control;
    assign frame_done  = receiving && (bit_cnt == LAST_BIT);
    assign frame_next  = {frame_q[FB-2:0], control};

    assign frame_match =
        (frame_next[START_MSB -: $bits(slave_pkg::START_CODE)] == slave_pkg::START_CODE) &&
        (frame_next[ID_MSB -: slave_pkg::ID_WIDTH] == SLAVE_ID);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            receiving <= 1'b0;
            bit_cnt   <= '0;
            cfg_valid <= 1'b0;
        end else begin
            cfg_valid <= 1'b0;
            if (frame_start) begin
                receiving <= 1'b1;
                bit_cnt   <= bit_cnt_t'(1);
            end else if (frame_done) begin
                // mismatching frames end here without a strobe
                receiving <= 1'b0;
                bit_cnt   <= '0;
                cfg_valid <= frame_match;
            end else if (receiving) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // frame bits and decoded fields
    always_ff @(posedge clk) begin
        if (frame_start || receiving) begin
            frame_q <= frame_next;
        end
        if (frame_done) begin
            cfg <= slave_pkg::xfer_cfg_t'(frame_next[CFG_BITS-1:0]);
        end
    end

    // decision falls on the last of FB frame bits
    a_frame_length : assert property (
        @(posedge clk) disable iff (!rstN) frame_start |-> ##(FB - 1) frame_done
    );

endmodule

/* design/serial_slave.sv */
//----------------------------
// serial slave top
// connects setup receiver, write path, controller
// and word RAM to the bus pins
//----------------------------
module serial_slave #(
    parameter slave_pkg::slave_id_t SLAVE_ID = 2'd1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic rd_valid,
    output logic ready
);

    slave_pkg::xfer_cfg_t cfg;
    slave_pkg::wr_word_t  word;
    slave_pkg::addr_t     addr;
    slave_pkg::data_t     wdata;
    slave_pkg::data_t     rdata;
    logic                 cfg_valid;
    logic                 word_valid;
    logic                 busy;
    logic                 wr_enable;
    logic                 we;

    config_receiver #(
        .SLAVE_ID (SLAVE_ID)
    ) config_receiver_i (
        .clk       (clk),
        .rstN      (rstN),
        .control   (control),
        .busy      (busy),
        .cfg_valid (cfg_valid),
        .cfg       (cfg)
    );

    write_deserializer write_deserializer_i (
        .clk        (clk),
        .rstN       (rstN),
        .wD         (wD),
        .valid      (valid),
        .last       (last),
        .enable     (wr_enable),
        .word_valid (word_valid),
        .word       (word)
    );

    transfer_controller transfer_controller_i (
        .clk        (clk),
        .rstN       (rstN),
        .cfg_valid  (cfg_valid),
        .cfg        (cfg),
        .word_valid (word_valid),
        .word       (word),
        .last       (last),
        .rdata      (rdata),
        .busy       (busy),
        .wr_enable  (wr_enable),
        .we         (we),
        .addr       (addr),
        .wdata      (wdata),
        .rD         (rD),
        .rd_valid   (rd_valid),
        .ready      (ready)
    );

    word_memory word_memory_i (
        .clk   (clk),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .rdata (rdata)
    );

endmodule

/* design/slave_pkg.sv */
//----------------------------
// serial slave package
// bus constants, word and address types, the decoded
// setup and write word structs, controller states
//----------------------------
package slave_pkg;

    // memory geometry
    localparam int DATA_WIDTH = 32;
    localparam int MEM_DEPTH  = 256;
    localparam int ADDR_WIDTH = $clog2(MEM_DEPTH);

    // frame layout: start | id | r/w | burst | address
    localparam int         ID_WIDTH   = 2;
    localparam logic [2:0] START_CODE = 3'b111;
    localparam int         FRAME_BITS = $bits(START_CODE) + ID_WIDTH + 1 + 1 + ADDR_WIDTH;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ID_WIDTH-1:0]   slave_id_t;

    // field order matches the tail of the frame
    typedef struct packed {
        logic  is_write;
        logic  burst;
        addr_t start_addr;
    } xfer_cfg_t;

    typedef struct packed {
        data_t data;
        logic  last;
    } wr_word_t;

    typedef enum logic [1:0] {
        IDLE,
        WR_WAIT,
        RD_FETCH,
        RD_SHIFT
    } ctrl_state_e;

endpackage

/* design/transfer_controller.sv */
//----------------------------
// transfer controller
// runs read and write transfers after a setup strobe,
// drives the RAM, serializes read words onto rD and
// ends bursts on last
//----------------------------
module transfer_controller (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 cfg_valid,
    input  slave_pkg::xfer_cfg_t cfg,
    input  logic                 word_valid,
    input  slave_pkg::wr_word_t  word,
    input  logic                 last,
    input  slave_pkg::data_t     rdata,
    output logic                 busy,
    output logic                 wr_enable,
    output logic                 we,
    output slave_pkg::addr_t     addr,
    output slave_pkg::data_t     wdata,
    output logic                 rD,
    output logic                 rd_valid,
    output logic                 ready
);

    localparam int DW    = slave_pkg::DATA_WIDTH;
    localparam int CNT_W = $clog2(DW);

    // two cycles from address to loaded shift register
    localparam logic [CNT_W-1:0] FETCH_LAST = CNT_W'(1);
    localparam logic [CNT_W-1:0] LAST_BIT   = CNT_W'(DW - 1);

    slave_pkg::ctrl_state_e state;
    slave_pkg::addr_t       addr_q;
    slave_pkg::data_t       shift_q;
    logic [CNT_W-1:0]       bit_cnt;
    logic                   burst_q;
    logic                   last_seen;
    logic                   fetch_done;
    logic                   word_end;
    logic                   stop_read;

    assign fetch_done = (state == slave_pkg::RD_FETCH) && (bit_cnt == FETCH_LAST);
    assign word_end   = (state == slave_pkg::RD_SHIFT) && (bit_cnt == LAST_BIT);
    assign stop_read  = last || last_seen || !burst_q;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= slave_pkg::IDLE;
            addr_q    <= '0;
            bit_cnt   <= '0;
            burst_q   <= 1'b0;
            last_seen <= 1'b0;
        end else begin
            case (state)
                slave_pkg::IDLE: begin
                    if (cfg_valid) begin
                        addr_q    <= cfg.start_addr;
                        burst_q   <= cfg.burst;
                        bit_cnt   <= '0;
                        last_seen <= 1'b0;
                        state     <= cfg.is_write ? slave_pkg::WR_WAIT : slave_pkg::RD_FETCH;
                    end
                end
                slave_pkg::WR_WAIT: begin
                    // word goes to RAM in this same cycle
                    if (word_valid) begin
                        if (burst_q && !word.last) begin
                            addr_q <= addr_q + 1'b1;
                        end else begin
                            state <= slave_pkg::IDLE;
                        end
                    end
                end
                slave_pkg::RD_FETCH: begin
                    if (fetch_done) begin
                        bit_cnt <= '0;
                        state   <= slave_pkg::RD_SHIFT;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                slave_pkg::RD_SHIFT: begin
                    if (word_end) begin
                        bit_cnt   <= '0;
                        last_seen <= 1'b0;
                        if (stop_read) begin
                            state <= slave_pkg::IDLE;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                            state  <= slave_pkg::RD_FETCH;
                        end
                    end else begin
                        bit_cnt   <= bit_cnt + 1'b1;
                        last_seen <= last_seen || last;
                    end
                end
                default: state <= slave_pkg::IDLE;
            endcase
        end
    end

    // read word shifts out MSB first
    always_ff @(posedge clk) begin
        if (fetch_done) begin
            shift_q <= rdata;
        end else if (state == slave_pkg::RD_SHIFT) begin
            shift_q <= {shift_q[DW-2:0], 1'b0};
        end
    end

    // busy covers the strobe cycle so no new frame starts before the state moves
    assign busy      = cfg_valid || (state != slave_pkg::IDLE);
    assign wr_enable = (state == slave_pkg::WR_WAIT);
    assign we        = wr_enable && word_valid;
    assign addr      = addr_q;
    assign wdata     = word.data;
    assign rD        = shift_q[DW-1];
    assign rd_valid  = (state == slave_pkg::RD_SHIFT);
    assign ready     = (state == slave_pkg::IDLE) || (state == slave_pkg::WR_WAIT);

    // busy holds off new frames, so setups only land in IDLE
    a_cfg_in_idle : assert property (
        @(posedge clk) disable iff (!rstN) cfg_valid |-> (state == slave_pkg::IDLE)
    );

endmodule

/* design/word_memory.sv */
//----------------------------
// word memory
// single-port RAM with registered read
//----------------------------
module word_memory (
    input  logic             clk,
    input  logic             we,
    input  slave_pkg::addr_t addr,
    input  slave_pkg::data_t wdata,
    output slave_pkg::data_t rdata
);

    slave_pkg::data_t mem [slave_pkg::MEM_DEPTH];

    // read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

/* design/write_deserializer.sv */
//----------------------------
// write deserializer
// collects MSB-first write bits from wD on valid cycles
// and strobes each finished word with its last flag
//----------------------------
module write_deserializer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                wD,
    input  logic                valid,
    input  logic                last,
    input  logic                enable,
    output logic                word_valid,
    output slave_pkg::wr_word_t word
);

    localparam int DW    = slave_pkg::DATA_WIDTH;
    localparam int CNT_W = $clog2(DW);

    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(DW - 1);

    slave_pkg::data_t shift_q;
    logic [CNT_W-1:0] bit_cnt;
    logic             last_seen;
    logic             take_bit;
    logic             word_done;

    assign take_bit  = enable && valid;
    assign word_done = take_bit && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt    <= '0;
            last_seen  <= 1'b0;
            word_valid <= 1'b0;
        end else if (!enable) begin
            // a partial word is dropped once the write ends
            bit_cnt    <= '0;
            last_seen  <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= word_done;
            if (word_done) begin
                bit_cnt   <= '0;
                last_seen <= 1'b0;
            end else if (take_bit) begin
                bit_cnt   <= bit_cnt + 1'b1;
                last_seen <= last_seen || last;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_bit) begin
            shift_q <= {shift_q[DW-2:0], wD};
        end
        if (word_done) begin
            word.data <= {shift_q[DW-2:0], wD};
            word.last <= last_seen || last;
        end
    end

    a_word_needs_enable : assert property (
        @(posedge clk) disable iff (!rstN) word_valid |-> enable
    );

endmodule

/* verification/slave_golden.txt */
# columns: op id burst addr count words (hex), one transaction per line
# op W writes, R reads and compares, B writes with a broken start pattern
W 1 0 10 1 deadbeef
R 1 0 10 1 deadbeef
W 1 0 24 1 0badf00d
W 1 1 20 4 11111111 22222222 33333333 44444444
R 1 1 20 4 11111111 22222222 33333333 44444444
R 1 0 24 1 0badf00d
W 2 0 10 1 ffffffff
B 1 0 10 1 12345678
R 1 0 10 1 deadbeef
R 3 0 10 1 00000000
W 1 0 80 1 a5c3e187
R 1 0 80 1 a5c3e187
W 1 1 40 2 cafe0001 cafe0002
R 1 1 40 2 cafe0001 cafe0002
R 1 0 41 1 cafe0002

/* verification/tb_serial_slave.sv */
//----------------------------
// serial slave testbench
// replays golden transactions on the serial pins
// and compares read words
//----------------------------
module tb_serial_slave;

    localparam int DW  = slave_pkg::DATA_WIDTH;
    localparam int FB  = slave_pkg::FRAME_BITS;
    localparam int MAX_TR = 64;
    localparam int MAX_WORDS = 512;
    localparam logic [1:0] DUT_ID = 2'd1;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic rd_valid;
    logic ready;

    // golden transactions
    byte              ops [MAX_TR];
    logic [1:0]       ids [MAX_TR];
    logic             bursts [MAX_TR];
    slave_pkg::addr_t addrs [MAX_TR];
    int               counts [MAX_TR];
    int               first_word [MAX_TR];
    slave_pkg::data_t words [MAX_WORDS];
    int               n_tr;
    int               n_words;
    int               mismatch_count;
    int               other_count;
    longint           limit;
    logic             limit_set;

    serial_slave #(
        .SLAVE_ID (DUT_ID)
    ) serial_slave_i (
        .clk      (clk),
        .rstN     (rstN),
        .control  (control),
        .wD       (wD),
        .valid    (valid),
        .last     (last),
        .rD       (rD),
        .rd_valid (rd_valid),
        .ready    (ready)
    );

    always #2 clk = ~clk;

    // one cycle, then settle past the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic load_golden();
        int    fd;
        int    rc;
        string tok;
        string rest;
        int    id_v;
        int    b_v;
        int    a_v;
        int    c_v;
        fd = $fopen("verification/slave_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open golden file");
            other_count++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                rc = $fgets(rest, fd);
            end else begin
                rc = $fscanf(fd, "%h %h %h %h", id_v, b_v, a_v, c_v);
                ops[n_tr]        = tok.getc(0);
                ids[n_tr]        = id_v[1:0];
                bursts[n_tr]     = b_v[0];
                addrs[n_tr]      = a_v[7:0];
                counts[n_tr]     = c_v;
                first_word[n_tr] = n_words;
                for (int i = 0; i < c_v; i++) begin
                    rc = $fscanf(fd, "%h", words[n_words]);
                    n_words++;
                end
                n_tr++;
            end
        end
        $fclose(fd);
    endtask

    task automatic send_frame(input logic [2:0] start, input logic [1:0] id,
                              input logic is_write, input logic burst,
                              input slave_pkg::addr_t addr);
        logic [FB-1:0] frame;
        frame = {start, id, is_write, burst, addr};
        for (int i = FB - 1; i >= 0; i--) begin
            control = frame[i];
            step();
        end
        control = 1'b0;
    endtask

    task automatic write_words(input int t);
        slave_pkg::data_t w;
        int gap;
        // strobe cycle, then WR_WAIT
        step();
        for (int n = 0; n < counts[t]; n++) begin
            w = words[first_word[t] + n];
            for (int b = DW - 1; b >= 0; b--) begin
                gap = $urandom % 4;
                valid = 1'b0;
                repeat (gap) begin
                    if (ready !== 1'b1) begin
                        $display("ready low while write waits for bits, transaction %0d", t);
                        other_count++;
                    end
                    step();
                end
                valid = 1'b1;
                wD    = w[b];
                last  = bursts[t] && (n == counts[t] - 1) && (b == 0);
                step();
            end
        end
        valid = 1'b0;
        last  = 1'b0;
        step();
        step();
    endtask

    task automatic read_words(input int t);
        slave_pkg::data_t got;
        int               wait_cnt;
        for (int n = 0; n < counts[t]; n++) begin
            wait_cnt = 0;
            while (rd_valid !== 1'b1 && wait_cnt < 10) begin
                step();
                wait_cnt++;
            end
            if (rd_valid !== 1'b1) begin
                $display("rd_valid never rose, transaction %0d word %0d", t, n);
                other_count++;
                return;
            end
            last = bursts[t] && (n == counts[t] - 1);
            for (int b = DW - 1; b >= 0; b--) begin
                if (rd_valid !== 1'b1) begin
                    $display("rd_valid dropped inside a word, transaction %0d", t);
                    other_count++;
                end
                got[b] = rD;
                step();
            end
            last = 1'b0;
            if (rd_valid !== 1'b0) begin
                $display("rd_valid longer than one word, transaction %0d", t);
                other_count++;
            end
            if (got !== words[first_word[t] + n]) begin
                $display("MISMATCH read_t%0d_w%0d expected %h actual %h",
                         t, n, words[first_word[t] + n], got);
                mismatch_count++;
            end
            if (n == counts[t] - 1) begin
                // no further word may follow the last one
                wait_cnt = 0;
                while (rd_valid === 1'b0 && wait_cnt < 3) begin
                    step();
                    wait_cnt++;
                end
                if (rd_valid !== 1'b0) begin
                    $display("read did not stop after its last word, transaction %0d", t);
                    other_count++;
                end
            end
        end
    endtask

    // dropped frames must never start a read
    task automatic expect_quiet(input int t);
        repeat (FB + 8) begin
            if (rd_valid !== 1'b0) begin
                $display("rd_valid rose after a dropped frame, transaction %0d", t);
                other_count++;
            end
            step();
        end
    endtask

    initial begin
        wait (limit_set);
        #(limit);
        $display("timeout: transfers did not finish within %0d time units", limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [2:0] start;
        longint     total;
        clk = 1'b0;
        rstN = 1'b0;
        control = 1'b0;
        wD = 1'b0;
        valid = 1'b0;
        last = 1'b0;
        n_tr = 0;
        n_words = 0;
        mismatch_count = 0;
        other_count = 0;
        limit_set = 1'b0;
        void'($urandom(32'h064d_cf84));
        load_golden();
        total = 0;
        for (int t = 0; t < n_tr; t++) begin
            total += longint'(FB + 8 + 3 * DW) * counts[t];
        end
        limit = total * 4 + 5000;
        limit_set = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        step();
        if (ready !== 1'b1 || rd_valid !== 1'b0) begin
            $display("reset state wrong, ready %b rd_valid %b", ready, rd_valid);
            other_count++;
        end

        for (int t = 0; t < n_tr; t++) begin
            repeat ($urandom % 4) step();
            start = (ops[t] == "B") ? 3'b101 : slave_pkg::START_CODE;
            send_frame(start, ids[t], ops[t] != "R", bursts[t], addrs[t]);
            if (ops[t] == "B" || ids[t] != DUT_ID) begin
                // bits of a dropped write must not reach the RAM
                if (ops[t] != "R") begin
                    write_words(t);
                end
                expect_quiet(t);
            end else if (ops[t] == "W") begin
                write_words(t);
            end else begin
                read_words(t);
            end
        end

        $display("errors: mismatches %0d, other %0d", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
